// File: include/hdmiIsland_params.svh
//################################################
// HDMI data island constants
// Character counts of each island phase, the
// guard-band symbol and the InfoFrame header codes
//################################################

`ifndef HDMI_ISLAND_PARAMS_SVH
`define HDMI_ISLAND_PARAMS_SVH

// Idle characters between the end of hSync and the preamble
`define ISLAND_WAIT_CHARS 42

// Control-period preamble that announces a data island
`define ISLAND_PREAMBLE_CHARS 8

// Length of each guard band, leading and trailing
`define ISLAND_GUARD_CHARS 2

// One packet is 32 TERC4 characters on each channel
`define ISLAND_PACKET_CHARS 32

// AVI on the first line of vSync, Audio on the second
`define ISLAND_PACKETS_PER_VSYNC 2

// Data island guard band sent on channels 1 and 2
`define GUARD_BAND_CODE 10'b0100110011

// AVI InfoFrame header bytes
`define AVI_INFOFRAME_TYPE 8'h82
`define AVI_INFOFRAME_VERSION 8'h02
`define AVI_INFOFRAME_LENGTH 8'd13

// Audio InfoFrame header bytes
`define AUDIO_INFOFRAME_TYPE 8'h84
`define AUDIO_INFOFRAME_VERSION 8'h01
`define AUDIO_INFOFRAME_LENGTH 8'd10

`endif

// File: source/hdmiIslandPkg.sv
//################################################
// HDMI data island package
// Symbol and byte types, the packet layout, the
// island phases and the TERC4 and control encoders
//################################################

`default_nettype none

package hdmiIslandPkg;

    // One encoded 10-bit character on one TMDS channel
    typedef logic [9:0] tmdsSymbol;

    // One raw data island character on one channel, before TERC4
    typedef logic [3:0] terc4Nibble;

    typedef logic [7:0] packetByte;

    // Three header bytes, byte 0 in the low bits
    typedef logic [23:0] packetHeader;

    // Seven subpacket bytes, byte 0 in the low bits
    typedef logic [55:0] subpacketBody;

    // A complete packet without its BCH parity bytes
    typedef struct packed {
        packetHeader  header;
        subpacketBody subpacket0;
        subpacketBody subpacket1;
        subpacketBody subpacket2;
        subpacketBody subpacket3;
    } infoFramePacket;

    // The three channel nibbles of one packet character
    typedef struct packed {
        terc4Nibble channel0;
        terc4Nibble channel1;
        terc4Nibble channel2;
    } islandNibbles;

    // Phase of the island whose symbols are on the outputs
    typedef enum logic [2:0] {
        idle,
        waitHsyncEnd,
        settle,
        preamble,
        leadGuard,
        packet,
        trailGuard
    } islandPhase;

    // TERC4 maps each nibble onto one of 16 DC-balanced symbols
    function automatic tmdsSymbol terc4Encode(input terc4Nibble nibble);
        tmdsSymbol symbol;
        case (nibble)
            4'h0: symbol = 10'b1010011100;
            4'h1: symbol = 10'b1001100011;
            4'h2: symbol = 10'b1011100100;
            4'h3: symbol = 10'b1011100010;
            4'h4: symbol = 10'b0101110001;
            4'h5: symbol = 10'b0100011110;
            4'h6: symbol = 10'b0110001110;
            4'h7: symbol = 10'b0100111100;
            4'h8: symbol = 10'b1011001100;
            4'h9: symbol = 10'b0100111001;
            4'hA: symbol = 10'b0110011100;
            4'hB: symbol = 10'b1011000110;
            4'hC: symbol = 10'b1010001110;
            4'hD: symbol = 10'b1001110001;
            4'hE: symbol = 10'b0101100011;
            default: symbol = 10'b1011000011;
        endcase
        return symbol;
    endfunction

    // Control period symbols, bit 1 is C1 (vSync on channel 0) and bit 0 is C0
    function automatic tmdsSymbol ctlEncode(input logic [1:0] ctl);
        tmdsSymbol symbol;
        case (ctl)
            2'b00: symbol = 10'b1101010100;
            2'b01: symbol = 10'b0010101011;
            2'b10: symbol = 10'b0101010100;
            default: symbol = 10'b1010101011;
        endcase
        return symbol;
    endfunction

endpackage

`default_nettype wire

// File: source/aviInfoFramePacket.sv
//################################################
// AVI InfoFrame packet builder
// Places the video format fields into the AVI
// byte layout and adds the checksum
//################################################

`default_nettype none

`include "hdmiIsland_params.svh"

module aviInfoFramePacket import hdmiIslandPkg::*; (
    input  wire logic [6:0] videoFormatCode,
    input  wire logic [1:0] rgbOrYuvCode,
    input  wire logic [1:0] yccQuantizationRange,
    output infoFramePacket  packet
);

    // Fixed fields: active format present, no bar data, underscan
    localparam logic       activeFormatPresent = 1'b1;
    localparam logic [1:0] barInfo = 2'b00;
    localparam logic [1:0] scanInfo = 2'b10;
    // No colorimetry given, 16:9 picture, active format same as picture
    localparam logic [1:0] colorimetry = 2'b00;
    localparam logic [1:0] pictureAspect = 2'b10;
    localparam logic [3:0] activeFormatAspect = 4'b1000;

    // Payload bytes PB0 to PB27, PB0 holds the checksum
    packetByte [27:0] payload;
    packetByte byteSum;

    always_comb begin
        payload = '0;
        payload[1] = {1'b0, rgbOrYuvCode, activeFormatPresent, barInfo, scanInfo};
        payload[2] = {colorimetry, pictureAspect, activeFormatAspect};
        // PB3 stays zero: no IT content, default extended colorimetry and RGB range
        payload[4] = {1'b0, videoFormatCode};
        // Content type and pixel repetition are zero
        payload[5] = {yccQuantizationRange, 2'b00, 4'b0000};

        // All header and payload bytes plus the checksum sum to zero
        byteSum = `AVI_INFOFRAME_TYPE + `AVI_INFOFRAME_VERSION + `AVI_INFOFRAME_LENGTH;
        for (int i = 1; i <= `AVI_INFOFRAME_LENGTH; i++) begin
            byteSum = byteSum + payload[i];
        end
        payload[0] = 8'd0 - byteSum;
    end

    assign packet.header = {`AVI_INFOFRAME_LENGTH, `AVI_INFOFRAME_VERSION, `AVI_INFOFRAME_TYPE};

    // Seven payload bytes per subpacket, lowest byte in the low bits
    assign packet.subpacket0 = payload[6:0];
    assign packet.subpacket1 = payload[13:7];
    assign packet.subpacket2 = payload[20:14];
    assign packet.subpacket3 = payload[27:21];

endmodule

`default_nettype wire

// File: source/audioInfoFramePacket.sv
//################################################
// Audio InfoFrame packet builder
// Constant two-channel Audio InfoFrame with
// its checksum
//################################################

`default_nettype none

`include "hdmiIsland_params.svh"

module audioInfoFramePacket import hdmiIslandPkg::*; (
    output infoFramePacket packet
);

    // Coding type from stream header, channel count field 1 means two channels
    localparam packetByte channelCountByte = 8'h01;

    localparam packetByte byteSum = packetByte'(`AUDIO_INFOFRAME_TYPE
        + `AUDIO_INFOFRAME_VERSION + `AUDIO_INFOFRAME_LENGTH + channelCountByte);

    // Every other field is zero so the checksum is a constant
    localparam packetByte checksum = packetByte'(0 - byteSum);

    packetByte [27:0] payload;

    always_comb begin
        payload = '0;
        payload[0] = checksum;
        payload[1] = channelCountByte;
    end

    assign packet.header = {`AUDIO_INFOFRAME_LENGTH, `AUDIO_INFOFRAME_VERSION,
                            `AUDIO_INFOFRAME_TYPE};

    assign packet.subpacket0 = payload[6:0];
    assign packet.subpacket1 = payload[13:7];
    assign packet.subpacket2 = payload[20:14];
    assign packet.subpacket3 = payload[27:21];

endmodule

`default_nettype wire

// File: source/dataIslandPacketSerializer.sv
//################################################
// Data island packet serializer
// Adds BCH parity to the header and subpackets and
// splits the packet into 32 TERC4 characters
//################################################

`default_nettype none

`include "hdmiIsland_params.svh"

module dataIslandPacketSerializer import hdmiIslandPkg::*; (
    input  wire logic     pixelClock,
    input  wire logic     rst,
    input  wire logic     packetStart,
    input  wire logic     hSync,
    input  wire logic     vSync,
    input  infoFramePacket packet,
    output islandNibbles  nibbles
);

    localparam logic [5:0] lastIndex = 6'(`ISLAND_PACKET_CHARS);

    // BCH parity over the first bitCount bits of data, fed LSB first.
    // The right-shifting register with feedback 0x83 is the bit-reversed
    // form of the generator x^8 + x^7 + x^6 + 1
    function automatic packetByte bchParity(input logic [55:0] data, input int bitCount);
        packetByte parity;
        logic feedback;
        parity = '0;
        for (int i = 0; i < 56; i++) begin
            if (i < bitCount) begin
                feedback = parity[0] ^ data[i];
                parity = (parity >> 1) ^ (feedback ? 8'h83 : 8'h00);
            end
        end
        return parity;
    endfunction

    // Header and its parity, sent one bit per character on channel 0
    logic [31:0] headerWord;
    // Each subpacket and its parity, sent two bits per character
    logic [3:0][63:0] subpacketWord;

    // Index of the next character, parked at 32 between packets
    logic [5:0] charIndex;
    logic [5:0] currentChar;
    logic [4:0] bitSel;
    logic charValid;

    assign headerWord = {bchParity(56'(packet.header), 24), packet.header};

    always_comb begin
        subpacketWord[0] = {bchParity(packet.subpacket0, 56), packet.subpacket0};
        subpacketWord[1] = {bchParity(packet.subpacket1, 56), packet.subpacket1};
        subpacketWord[2] = {bchParity(packet.subpacket2, 56), packet.subpacket2};
        subpacketWord[3] = {bchParity(packet.subpacket3, 56), packet.subpacket3};
    end

    always_ff @(posedge pixelClock) begin
        if (rst) begin
            charIndex <= lastIndex;
        end else if (packetStart) begin
            // Character 0 goes out in the start cycle itself
            charIndex <= 6'd1;
        end else if (charIndex != lastIndex) begin
            charIndex <= charIndex + 6'd1;
        end
    end

    // The output is combinational from the index so there is no latency
    always_comb begin
        currentChar = packetStart ? 6'd0 : charIndex;
        charValid = packetStart || (charIndex < lastIndex);
        bitSel = currentChar[4:0];

        // Bit 3 marks every character but the first of the packet
        nibbles.channel0 = {charValid && (currentChar != 6'd0),
                            charValid && headerWord[bitSel],
                            vSync,
                            hSync};

        // Bit k of channel 1 carries the even bit of subpacket k, channel 2 the odd bit
        for (int k = 0; k < 4; k++) begin
            nibbles.channel1[k] = charValid && subpacketWord[k][{bitSel, 1'b0}];
            nibbles.channel2[k] = charValid && subpacketWord[k][{bitSel, 1'b1}];
        end
    end

endmodule

`default_nettype wire

// File: source/vBlankDataIsland.sv
//################################################
// Vertical blanking data island generator
// Sends an AVI InfoFrame island on the first vSync
// line and an Audio InfoFrame island on the second
//################################################

`default_nettype none

`include "hdmiIsland_params.svh"

module vBlankDataIsland import hdmiIslandPkg::*; (
    input  wire logic       pixelClock,
    input  wire logic       rst,
    input  wire logic       hSync,
    input  wire logic       vSync,
    input  wire logic       syncIsActiveLow,
    input  wire logic [6:0] videoFormatCode,
    input  wire logic [1:0] rgbOrYuvCode,
    input  wire logic [1:0] yccQuantizationRange,
    output logic            dataIslandActive,
    output tmdsSymbol       channel0,
    output tmdsSymbol       channel1,
    output tmdsSymbol       channel2
);

    // Last character count of each phase, counted from the end of hSync
    localparam logic [6:0] settleEnd = 7'(`ISLAND_WAIT_CHARS - 1);
    localparam logic [6:0] preambleEnd = settleEnd + 7'(`ISLAND_PREAMBLE_CHARS);
    localparam logic [6:0] leadGuardEnd = preambleEnd + 7'(`ISLAND_GUARD_CHARS);
    localparam logic [6:0] packetEnd = leadGuardEnd + 7'(`ISLAND_PACKET_CHARS);
    localparam logic [6:0] trailGuardEnd = packetEnd + 7'(`ISLAND_GUARD_CHARS);

    islandPhase phase;
    islandPhase nextPhase;
    logic [6:0] charCount;
    logic [1:0] packetCount;
    logic packetStart;

    logic hSyncOn;
    logic vSyncOn;

    infoFramePacket aviPacket;
    infoFramePacket audioPacket;
    infoFramePacket selectedPacket;
    islandNibbles packetNibbles;

    // Sync inputs are active when they differ from the polarity flag
    assign hSyncOn = hSync ^ syncIsActiveLow;
    assign vSyncOn = vSync ^ syncIsActiveLow;

    aviInfoFramePacket aviBuilder (
        .videoFormatCode(videoFormatCode),
        .rgbOrYuvCode(rgbOrYuvCode),
        .yccQuantizationRange(yccQuantizationRange),
        .packet(aviPacket)
    );

    audioInfoFramePacket audioBuilder (
        .packet(audioPacket)
    );

    // AVI goes out on even packet counts, Audio on odd ones
    assign selectedPacket = packetCount[0] ? audioPacket : aviPacket;

    dataIslandPacketSerializer serializer (
        .pixelClock(pixelClock),
        .rst(rst),
        .packetStart(packetStart),
        .hSync(hSync),
        .vSync(vSync),
        .packet(selectedPacket),
        .nibbles(packetNibbles)
    );

    // Each phase ends when the count reaches its last character
    always_comb begin
        nextPhase = phase;
        case (phase)
            idle: begin
                if (hSyncOn && (packetCount < 2'(`ISLAND_PACKETS_PER_VSYNC))) begin
                    nextPhase = waitHsyncEnd;
                end
            end
            waitHsyncEnd: begin
                if (!hSyncOn) begin
                    nextPhase = settle;
                end
            end
            settle: if (charCount == settleEnd) nextPhase = preamble;
            preamble: if (charCount == preambleEnd) nextPhase = leadGuard;
            leadGuard: if (charCount == leadGuardEnd) nextPhase = packet;
            packet: if (charCount == packetEnd) nextPhase = trailGuard;
            trailGuard: if (charCount == trailGuardEnd) nextPhase = idle;
            default: nextPhase = idle;
        endcase
    end

    always_ff @(posedge pixelClock) begin
        if (rst || !vSyncOn) begin
            // Leaving vSync restarts the AVI and Audio sequence
            phase <= idle;
            charCount <= '0;
            packetCount <= '0;
            packetStart <= 1'b0;
            dataIslandActive <= 1'b0;
            channel0 <= '0;
            channel1 <= '0;
            channel2 <= '0;
        end else begin
            phase <= nextPhase;
            // Counting starts at the edge that sees hSync end
            charCount <= (phase inside {idle, waitHsyncEnd}) ? 7'd0 : charCount + 7'd1;
            if (phase == packet && nextPhase == trailGuard) begin
                packetCount <= packetCount + 2'd1;
            end
            // One cycle ahead of the first packet character
            packetStart <= (phase == leadGuard) && (charCount == leadGuardEnd - 7'd1);
            dataIslandActive <= nextPhase inside {preamble, leadGuard, packet, trailGuard};

            // The outputs follow the phase that starts at this edge
            case (nextPhase)
                preamble: begin
                    channel0 <= ctlEncode({vSync, hSync});
                    channel1 <= ctlEncode(2'b01);
                    channel2 <= ctlEncode(2'b01);
                end
                leadGuard, trailGuard: begin
                    channel0 <= terc4Encode({2'b11, vSync, hSync});
                    channel1 <= `GUARD_BAND_CODE;
                    channel2 <= `GUARD_BAND_CODE;
                end
                packet: begin
                    channel0 <= terc4Encode(packetNibbles.channel0);
                    channel1 <= terc4Encode(packetNibbles.channel1);
                    channel2 <= terc4Encode(packetNibbles.channel2);
                end
                default: begin
                    channel0 <= '0;
                    channel1 <= '0;
                    channel2 <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: tb/vBlankDataIslandTb.sv
//################################################
// Testbench for the vertical blanking data island
// generator. Runs vSync periods from a table of
// video settings and decodes the output symbols
//################################################

`default_nettype none

`include "hdmiIsland_params.svh"

module vBlankDataIslandTb import hdmiIslandPkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int linePeriod = 160;
    localparam int hSyncWidth = 10;
    localparam int maxLines = 4;
    localparam int rowCount = 6;
    localparam int gapCycles = 8;
    // E0 is the first clock that samples hSync inactive again
    localparam int edgeOffset = hSyncWidth + 1;
    // Character positions counted from E0
    localparam int preambleFirst = `ISLAND_WAIT_CHARS;
    localparam int guardFirst = preambleFirst + `ISLAND_PREAMBLE_CHARS;
    localparam int packetFirst = guardFirst + `ISLAND_GUARD_CHARS;
    localparam int trailFirst = packetFirst + `ISLAND_PACKET_CHARS;
    localparam int islandEnd = trailFirst + `ISLAND_GUARD_CHARS;
    // Each row also runs one line with vSync inactive ahead of its vSync lines
    localparam int timeoutCycles = rowCount * (maxLines + 1) * linePeriod
                                 + rowCount * 4 * gapCycles + 100;
    // Generator x^8 + x^7 + x^6 + 1
    localparam logic [8:0] bchGenerator = 9'h1C1;

    typedef struct packed {
        logic       activeLow;
        logic [6:0] videoCode;
        logic [1:0] colorSpace;
        logic [1:0] quantRange;
        logic [2:0] lineCount;
    } settingsRow;

    // Header and subpackets with their parity bytes in the top bits
    typedef struct packed {
        logic [31:0]      header;
        logic [3:0][63:0] subpackets;
    } packetWords;

    // Rows 0 and 1 differ only in the sync polarity
    settingsRow testTable [rowCount] = '{
        '{1'b0, 7'd16, 2'd0, 2'd0, 3'd4},
        '{1'b1, 7'd16, 2'd0, 2'd0, 3'd4},
        '{1'b0, 7'd4, 2'd2, 2'd1, 3'd2},
        '{1'b1, 7'd97, 2'd1, 2'd2, 3'd3},
        '{1'b0, 7'd127, 2'd3, 2'd3, 3'd1},
        '{1'b1, 7'd1, 2'd0, 2'd0, 3'd4}
    };

    tmdsSymbol terc4Table [16] = '{
        10'b1010011100, 10'b1001100011, 10'b1011100100, 10'b1011100010,
        10'b0101110001, 10'b0100011110, 10'b0110001110, 10'b0100111100,
        10'b1011001100, 10'b0100111001, 10'b0110011100, 10'b1011000110,
        10'b1010001110, 10'b1001110001, 10'b0101100011, 10'b1011000011
    };
    // Indexed by {C1, C0}
    tmdsSymbol ctlTable [4] = '{10'b1101010100, 10'b0010101011, 10'b0101010100, 10'b1010101011};
    packetByte bchTable [256];

    logic pixelClock = 1'b0;
    logic rst;
    logic hSync;
    logic vSync;
    logic syncIsActiveLow;
    logic [6:0] videoFormatCode;
    logic [1:0] rgbOrYuvCode;
    logic [1:0] yccQuantizationRange;
    logic dataIslandActive;
    tmdsSymbol channel0;
    tmdsSymbol channel1;
    tmdsSymbol channel2;
    int cycleCount = 0;

    vBlankDataIsland UUT (
        .pixelClock(pixelClock),
        .rst(rst),
        .hSync(hSync),
        .vSync(vSync),
        .syncIsActiveLow(syncIsActiveLow),
        .videoFormatCode(videoFormatCode),
        .rgbOrYuvCode(rgbOrYuvCode),
        .yccQuantizationRange(yccQuantizationRange),
        .dataIslandActive(dataIslandActive),
        .channel0(channel0),
        .channel1(channel1),
        .channel2(channel2)
    );

    always #50 pixelClock = ~pixelClock;

    always @(posedge pixelClock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            stopWithFailure($sformatf("Timeout: the run did not finish within %0d cycles",
                                      timeoutCycles));
        end
    end

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1);
    endtask

    // Byte table for the parity register, which shifts right because bits go in LSB first
    task automatic buildBchTable();
        packetByte reflected;
        packetByte crc;
        for (int i = 0; i < 8; i++) begin
            reflected[i] = bchGenerator[7 - i];
        end
        for (int v = 0; v < 256; v++) begin
            crc = 8'(v);
            for (int s = 0; s < 8; s++) begin
                crc = crc[0] ? ((crc >> 1) ^ reflected) : (crc >> 1);
            end
            bchTable[v] = crc;
        end
    endtask

    function automatic packetByte bchOver(input logic [55:0] data, input int byteCount);
        packetByte crc;
        crc = '0;
        for (int i = 0; i < byteCount; i++) begin
            crc = bchTable[crc ^ data[8*i +: 8]];
        end
        return crc;
    endfunction

    // Reference AVI or Audio InfoFrame built from the CEA-861 byte layout
    function automatic packetWords expectedPacket(input settingsRow row, input logic isAudio);
        packetByte [2:0] header;
        packetByte [27:0] body;
        packetByte sum;
        packetWords words;
        body = '0;
        if (isAudio) begin
            header = {`AUDIO_INFOFRAME_LENGTH, `AUDIO_INFOFRAME_VERSION, `AUDIO_INFOFRAME_TYPE};
            // Channel count 1 means two channels
            body[1] = 8'h01;
        end else begin
            header = {`AVI_INFOFRAME_LENGTH, `AVI_INFOFRAME_VERSION, `AVI_INFOFRAME_TYPE};
            // Y field, active format present, no bars, underscan
            body[1] = {1'b0, row.colorSpace, 1'b1, 2'b00, 2'b10};
            // 16:9 picture with the active format same as the picture
            body[2] = 8'b0010_1000;
            body[4] = {1'b0, row.videoCode};
            body[5] = {row.quantRange, 6'b000000};
        end
        sum = header[0] + header[1] + header[2];
        for (int i = 1; i < 28; i++) begin
            sum = sum + body[i];
        end
        body[0] = 8'd0 - sum;
        words.header = {bchOver({32'd0, header}, 3), header};
        for (int k = 0; k < 4; k++) begin
            words.subpackets[k] = {bchOver(body[7*k +: 7], 7), body[7*k +: 7]};
        end
        return words;
    endfunction

    // Returns {found, nibble}
    function automatic logic [4:0] decodeTerc4(input tmdsSymbol symbol);
        logic [4:0] result;
        result = '0;
        for (int n = 0; n < 16; n++) begin
            if (terc4Table[n] == symbol) begin
                result = {1'b1, 4'(n)};
            end
        end
        return result;
    endfunction

    task automatic checkSymbols(input logic expActive, input tmdsSymbol exp0,
                                input tmdsSymbol exp1, input tmdsSymbol exp2, input string where);
        assert ({dataIslandActive, channel0, channel1, channel2} === {expActive, exp0, exp1, exp2})
        else stopWithFailure($sformatf("ERR %0d ns: %s: got %b %h %h %h, expected %b %h %h %h",
            $time, where, dataIslandActive, channel0, channel1, channel2,
            expActive, exp0, exp1, exp2));
    endtask

    task automatic checkQuiet(input int cycles, input string where);
        repeat (cycles) begin
            @(negedge pixelClock);
            checkSymbols(1'b0, '0, '0, '0, where);
        end
    endtask

    // An hSync pulse while vSync is inactive must not start an island
    task automatic runLineOutsideVsync(input settingsRow row);
        logic activeLevel;
        activeLevel = !row.activeLow;
        for (int c = 0; c < linePeriod; c++) begin
            @(posedge pixelClock);
            hSync <= (c < hSyncWidth) ? activeLevel : !activeLevel;
            @(negedge pixelClock);
            checkSymbols(1'b0, '0, '0, '0, "line outside vSync");
        end
    endtask

    // One video line, checked and decoded one character at a time
    task automatic runLine(input settingsRow row, input int lineIndex);
        logic activeLevel;
        logic [1:0] syncBits;
        logic [4:0] d0;
        logic [4:0] d1;
        logic [4:0] d2;
        int k;
        int j;
        packetByte byteSum;
        packetWords got;
        packetWords want;
        string where;
        activeLevel = !row.activeLow;
        // Raw {vSync, hSync} levels while the island is sent
        syncBits = {activeLevel, !activeLevel};
        got = '0;
        want = expectedPacket(row, lineIndex == 1);
        for (int c = 0; c < linePeriod; c++) begin
            @(posedge pixelClock);
            hSync <= (c < hSyncWidth) ? activeLevel : !activeLevel;
            @(negedge pixelClock);
            k = c - edgeOffset;
            where = $sformatf("line %0d character %0d", lineIndex, k);
            if (lineIndex >= `ISLAND_PACKETS_PER_VSYNC || k < preambleFirst || k >= islandEnd) begin
                checkSymbols(1'b0, '0, '0, '0, where);
            end else if (k < guardFirst) begin
                checkSymbols(1'b1, ctlTable[syncBits], ctlTable[1], ctlTable[1], where);
            end else if (k < packetFirst || k >= trailFirst) begin
                checkSymbols(1'b1, terc4Table[{2'b11, syncBits}], `GUARD_BAND_CODE,
                             `GUARD_BAND_CODE, where);
            end else begin
                j = k - packetFirst;
                d0 = decodeTerc4(channel0);
                d1 = decodeTerc4(channel1);
                d2 = decodeTerc4(channel2);
                // Bit 3 of channel 0 is low only on the first character
                assert (dataIslandActive && d0[4] && d1[4] && d2[4] && d0[1:0] == syncBits
                        && d0[3] == (j != 0))
                else stopWithFailure($sformatf("ERR %0d ns: %s: bad packet symbols %h %h %h",
                                               $time, where, channel0, channel1, channel2));
                got.header[j] = d0[2];
                for (int b = 0; b < 4; b++) begin
                    got.subpackets[b][2*j] = d1[b];
                    got.subpackets[b][2*j + 1] = d2[b];
                end
            end
        end
        if (lineIndex < `ISLAND_PACKETS_PER_VSYNC) begin
            byteSum = got.header[7:0] + got.header[15:8] + got.header[23:16];
            for (int s = 0; s < 28; s++) begin
                byteSum = byteSum + got.subpackets[s / 7][8*(s % 7) +: 8];
            end
            assert (got === want && byteSum == 8'd0)
            else stopWithFailure($sformatf("ERR %0d ns: line %0d packet %h, expected %h",
                                           $time, lineIndex, got, want));
        end
    endtask

    task automatic runVsyncPeriod(input settingsRow row);
        // Polarity and both syncs change together so vSync stays inactive
        @(posedge pixelClock);
        syncIsActiveLow <= row.activeLow;
        hSync <= row.activeLow;
        vSync <= row.activeLow;
        videoFormatCode <= row.videoCode;
        rgbOrYuvCode <= row.colorSpace;
        yccQuantizationRange <= row.quantRange;
        checkQuiet(gapCycles, "before vSync");
        runLineOutsideVsync(row);
        @(posedge pixelClock);
        vSync <= !row.activeLow;
        checkQuiet(gapCycles, "start of vSync");
        for (int line = 0; line < int'(row.lineCount); line++) begin
            runLine(row, line);
        end
        @(posedge pixelClock);
        vSync <= row.activeLow;
        checkQuiet(gapCycles, "after vSync");
    endtask

    initial begin
        rst = 1'b1;
        hSync = 1'b0;
        vSync = 1'b0;
        syncIsActiveLow = 1'b0;
        videoFormatCode = '0;
        rgbOrYuvCode = '0;
        yccQuantizationRange = '0;
        buildBchTable();
        repeat (5) @(posedge pixelClock);
        rst <= 1'b0;
        checkQuiet(1, "after reset");
        for (int r = 0; r < rowCount; r++) begin
            runVsyncPeriod(testTable[r]);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
source/hdmiIslandPkg.sv
source/aviInfoFramePacket.sv
source/audioInfoFramePacket.sv
source/dataIslandPacketSerializer.sv
source/vBlankDataIsland.sv
tb/vBlankDataIslandTb.sv

// File: run.sh
#!/bin/sh
# Builds the data island testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

logFile=sim.log

verilator --binary --assert --timescale 1ns/1ps -f tb.f \
    --top-module vBlankDataIslandTb --Mdir obj_dir -o vBlankDataIslandTb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/vBlankDataIslandTb > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^Verification passed$" "$logFile"; then
    exit 0
fi
echo "Pass message not found in $logFile"
exit 1
